// File: Bender.yml
package:
  name: pi1_wb4

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pi1_pkg.sv
      - wb4_fifo.sv
      - pi1_to_wb4.sv
      - wb4_sram.sv
      - pi1_wb4_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pi1_wb4_checker.sv
      - tb_pi1_wb4.sv

// File: flist.f
+incdir+.
pi1_pkg.sv
wb4_fifo.sv
pi1_to_wb4.sv
wb4_sram.sv
pi1_wb4_top.sv
pi1_wb4_checker.sv
tb_pi1_wb4.sv

// File: pi1_defines.svh
// Bus and buffer sizes for the PI1 to Wishbone B4 subsystem.
// Included by the package, the RTL and the testbench.
`ifndef PI1_DEFINES_SVH
`define PI1_DEFINES_SVH

// Data width in bits.
`define PI1_ARCHBITSZ 32

// One byte select per data byte.
`define PI1_SELBITSZ (`PI1_ARCHBITSZ / 8)

// PI1 word address width, 256 words.
`define PI1_ADDRBITSZ 8

// Entries in each slave buffer.
`define PI1_FIFO_DEPTH 2

`endif

// File: pi1_pkg.sv
// Types shared by the bridge, the memory slave and the testbench.
// Referenced by scoped names only.
`default_nettype none

`include "pi1_defines.svh"

package pi1_pkg;

	// PI1 operation codes.
	typedef enum logic [1:0] {
		NOOP = 2'b00,
		WROP = 2'b01,
		RDOP = 2'b10,
		RWOP = 2'b11
	} pi1_op_e;

	// Wishbone request, 69 bits.
	typedef struct packed {
		logic                        we;
		logic [`PI1_ARCHBITSZ-1:0]   adr;
		logic [`PI1_ARCHBITSZ-1:0]   dat;
		logic [`PI1_SELBITSZ-1:0]    sel;
	} wb4_req_t;

	// Wishbone response, read data only.
	typedef struct packed {
		logic [`PI1_ARCHBITSZ-1:0]   dat;
	} wb4_rsp_t;

endpackage

`default_nettype wire

// File: pi1_to_wb4.sv
// Bridge from one PI1 operation to Wishbone B4 pipelined cycles.
// A swap runs as a read followed by a write within one cycle.
`timescale 1ns/1ns
`default_nettype none

`include "pi1_defines.svh"

module pi1_to_wb4 (
	input  logic                        clk_i,
	input  logic                        arst_n_i,

	input  pi1_pkg::pi1_op_e            pi1_op_i,
	input  logic [`PI1_ADDRBITSZ-1:0]   pi1_addr_i,
	input  logic [`PI1_ARCHBITSZ-1:0]   pi1_data_i,
	input  logic [`PI1_SELBITSZ-1:0]    pi1_sel_i,
	output logic [`PI1_ARCHBITSZ-1:0]   pi1_data_o,
	output logic                        pi1_rdy_o,

	output logic                        wb4_cyc_o,
	output logic                        wb4_stb_o,
	output pi1_pkg::wb4_req_t           wb4_req_o,
	input  logic                        wb4_stall_i,
	input  logic                        wb4_ack_i,
	input  pi1_pkg::wb4_rsp_t           wb4_rsp_i
);

	localparam int BIDX_W = $clog2(`PI1_SELBITSZ);

	logic [BIDX_W-1:0]              byte_idx;
	logic [`PI1_ARCHBITSZ-1:0]      byte_adr;
	logic                           issue;
	logic                           last_ack;
	logic                           swap_ack;
	logic                           wr_pending_q;
	pi1_pkg::pi1_op_e               op_q;
	pi1_pkg::wb4_req_t              req_q;
	logic [`PI1_ARCHBITSZ-1:0]      data_q;

	// Lowest set byte select gives the byte offset.
	always_comb begin
		byte_idx = '0;
		for (int i = `PI1_SELBITSZ - 1; i >= 0; i--) begin
			if (pi1_sel_i[i]) begin
				byte_idx = BIDX_W'(i);
			end
		end
	end

	assign byte_adr = `PI1_ARCHBITSZ'({pi1_addr_i, byte_idx});

	assign pi1_rdy_o = !wb4_cyc_o;
	assign issue     = pi1_rdy_o && (pi1_op_i != pi1_pkg::NOOP);
	assign last_ack  = wb4_cyc_o && wb4_ack_i && !wr_pending_q;
	assign swap_ack  = wb4_cyc_o && wb4_ack_i && wr_pending_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb4_cyc_o    <= 1'b0;
			wb4_stb_o    <= 1'b0;
			wr_pending_q <= 1'b0;
			op_q         <= pi1_pkg::NOOP;
		end else if (last_ack) begin
			wb4_cyc_o <= 1'b0;
			wb4_stb_o <= 1'b0;
		end else if (issue) begin
			wb4_cyc_o    <= 1'b1;
			wb4_stb_o    <= 1'b1;
			op_q         <= pi1_op_i;
			wr_pending_q <= (pi1_op_i == pi1_pkg::RWOP);
		end else if (swap_ack) begin
			// Old word is back, start the write half.
			wb4_stb_o    <= 1'b1;
			wr_pending_q <= 1'b0;
		end else if (!wb4_stall_i) begin
			wb4_stb_o <= 1'b0;
		end
	end

	// Request held stable for the whole cycle.
	always_ff @(posedge clk_i) begin
		if (issue) begin
			req_q.we  <= (pi1_op_i == pi1_pkg::WROP);
			req_q.adr <= byte_adr;
			req_q.dat <= pi1_data_i;
			req_q.sel <= pi1_sel_i;
		end else if (swap_ack) begin
			req_q.we <= 1'b1;
		end
	end

	// Read data on the last ack of a read or the first ack of a swap.
	always_ff @(posedge clk_i) begin
		if (swap_ack || (last_ack && op_q == pi1_pkg::RDOP)) begin
			data_q <= wb4_rsp_i.dat;
		end
	end

	assign wb4_req_o  = req_q;
	assign pi1_data_o = data_q;

endmodule

`default_nettype wire

// File: pi1_wb4_checker.sv
// Concurrent Wishbone checks between the bridge and the memory slave.
// Bound into the subsystem top level by the bind statement at the end.
`timescale 1ns/1ns
`default_nettype none

module pi1_wb4_checker (
	input logic                clk_i,
	input logic                arst_n_i,
	input logic                wb4_cyc_i,
	input logic                wb4_stb_i,
	input pi1_pkg::wb4_req_t   wb4_req_i,
	input logic                wb4_stall_i,
	input logic                wb4_ack_i
);

	int unsigned fail_cnt = 0;

	// A strobe only inside a bus cycle.
	stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb4_stb_i |-> wb4_cyc_i)
		else begin
			fail_cnt++;
			$error("stb high while cyc is low");
		end

	// Stalled request stays on the bus unchanged.
	req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb4_stb_i && wb4_stall_i |=> wb4_stb_i && $stable(wb4_req_i))
		else begin
			fail_cnt++;
			$error("request dropped or changed while stalled");
		end

	// No ack outside a cycle.
	ack_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb4_ack_i |-> wb4_cyc_i)
		else begin
			fail_cnt++;
			$error("ack high while cyc is low");
		end

endmodule

bind pi1_wb4_top pi1_wb4_checker u_checker (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.wb4_cyc_i   (wb4_cyc),
	.wb4_stb_i   (wb4_stb),
	.wb4_req_i   (wb4_req),
	.wb4_stall_i (wb4_stall),
	.wb4_ack_i   (wb4_ack)
);

`default_nettype wire

// File: pi1_wb4_top.sv
// Memory subsystem top level with the PI1 port on the outside.
// The bridge drives the Wishbone memory slave directly.
`timescale 1ns/1ns
`default_nettype none

`include "pi1_defines.svh"

module pi1_wb4_top (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  pi1_pkg::pi1_op_e            pi1_op_i,
	input  logic [`PI1_ADDRBITSZ-1:0]   pi1_addr_i,
	input  logic [`PI1_ARCHBITSZ-1:0]   pi1_data_i,
	input  logic [`PI1_SELBITSZ-1:0]    pi1_sel_i,
	output logic [`PI1_ARCHBITSZ-1:0]   pi1_data_o,
	output logic                        pi1_rdy_o
);

	// Wishbone between bridge and slave.
	logic                   wb4_cyc;
	logic                   wb4_stb;
	pi1_pkg::wb4_req_t      wb4_req;
	logic                   wb4_stall;
	logic                   wb4_ack;
	pi1_pkg::wb4_rsp_t      wb4_rsp;

	pi1_to_wb4 u_bridge (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.wb4_cyc_o   (wb4_cyc),
		.wb4_stb_o   (wb4_stb),
		.wb4_req_o   (wb4_req),
		.wb4_stall_i (wb4_stall),
		.wb4_ack_i   (wb4_ack),
		.wb4_rsp_i   (wb4_rsp)
	);

	wb4_sram u_sram (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.wb4_cyc_i   (wb4_cyc),
		.wb4_stb_i   (wb4_stb),
		.wb4_req_i   (wb4_req),
		.wb4_stall_o (wb4_stall),
		.wb4_ack_o   (wb4_ack),
		.wb4_rsp_o   (wb4_rsp)
	);

endmodule

`default_nettype wire

// File: tb_pi1_wb4.sv
// Testbench for the PI1 to Wishbone B4 memory subsystem.
// Directed and LFSR driven PI1 operations, checked against a reference memory.
`timescale 1ns/1ns
`default_nettype none

`include "pi1_defines.svh"

module tb_pi1_wb4;

	localparam int     CLK_PERIOD  = 10;
	localparam int     N_OPS       = 400;
	localparam int     OP_CYCLES   = 40;
	localparam int     WORDS       = 2 ** `PI1_ADDRBITSZ;
	localparam longint WATCHDOG_NS = longint'(N_OPS + 32) * OP_CYCLES * CLK_PERIOD;

	logic                        clk;
	logic                        arst_n;
	pi1_pkg::pi1_op_e            pi1_op;
	logic [`PI1_ADDRBITSZ-1:0]   pi1_addr;
	logic [`PI1_ARCHBITSZ-1:0]   pi1_wdata;
	logic [`PI1_SELBITSZ-1:0]    pi1_sel;
	logic [`PI1_ARCHBITSZ-1:0]   pi1_rdata;
	logic                        pi1_rdy;

	logic [`PI1_ARCHBITSZ-1:0]   ref_mem [WORDS];
	logic [`PI1_ARCHBITSZ-1:0]   exp_rdata;
	logic [15:0]                 lfsr_q;
	int unsigned                 n_checks;
	int unsigned                 n_errors;

	pi1_wb4_top dut (
		.clk_i      (clk),
		.arst_n_i   (arst_n),
		.pi1_op_i   (pi1_op),
		.pi1_addr_i (pi1_addr),
		.pi1_data_i (pi1_wdata),
		.pi1_sel_i  (pi1_sel),
		.pi1_data_o (pi1_rdata),
		.pi1_rdy_o  (pi1_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// Selected bytes come from the new word.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rdy(input logic exp);
		n_checks++;
		assert (pi1_rdy === exp) else begin
			n_errors++;
			$display("[ERROR] %0t pi1_rdy_o: got %b, expected %b", $time, pi1_rdy, exp);
		end
	endtask

	// One PI1 operation from issue to the return of ready.
	task automatic run_op(input pi1_pkg::pi1_op_e op, input logic [7:0] addr,
			input logic [31:0] wdata, input logic [3:0] sel);
		int          waited;
		@(negedge clk);
		check_rdy(1'b1);
		@(posedge clk);
		pi1_op    <= op;
		pi1_addr  <= addr;
		pi1_wdata <= wdata;
		pi1_sel   <= sel;
		case (op)
			pi1_pkg::RDOP: exp_rdata = ref_mem[addr];
			pi1_pkg::WROP: ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, sel);
			pi1_pkg::RWOP: begin
				exp_rdata     = ref_mem[addr];
				ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, sel);
			end
			default: ;
		endcase
		@(posedge clk);
		pi1_op <= pi1_pkg::NOOP;
		if (op == pi1_pkg::NOOP) begin
			repeat (3) begin
				@(negedge clk);
				check_rdy(1'b1);
				check_word("pi1_data_o", pi1_rdata, exp_rdata);
			end
			return;
		end
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!pi1_rdy && waited < OP_CYCLES);
		n_checks++;
		assert (pi1_rdy) else begin
			n_errors++;
			$display("%0t: %s at word %h did not complete in %0d cycles",
				$time, op.name(), addr, OP_CYCLES);
		end
		check_word("pi1_data_o", pi1_rdata, exp_rdata);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all operations finished.");
		$display("test failed");
		$finish;
	end

	initial begin
		logic [31:0] r_op;
		logic [31:0] r_addr;
		logic [31:0] r_data;
		logic [31:0] r_sel;
		n_checks = 0;
		n_errors = 0;
		lfsr_q   = 16'd13;
		// Read data is unknown until the first read completes.
		exp_rdata = 'x;
		for (int i = 0; i < WORDS; i++) begin
			ref_mem[i] = '0;
		end
		arst_n    <= 1'b0;
		pi1_op    <= pi1_pkg::NOOP;
		pi1_addr  <= '0;
		pi1_wdata <= '0;
		pi1_sel   <= '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;

		// Ready stays high while idle after reset.
		repeat (8) begin
			@(negedge clk);
			check_rdy(1'b1);
		end

		// Untouched words read as zero.
		run_op(pi1_pkg::RDOP, 8'h80, '0, 4'hF);
		run_op(pi1_pkg::RDOP, 8'hFF, '0, 4'hF);

		run_op(pi1_pkg::WROP, 8'h40, 32'hA5C3_5A3C, 4'b0101);
		run_op(pi1_pkg::RDOP, 8'h40, '0, 4'hF);
		check_word("pi1_data_o", pi1_rdata, 32'h00C3_003C);

		// Swap hands back the old word.
		run_op(pi1_pkg::RWOP, 8'h40, 32'h1122_3344, 4'b1010);
		check_word("pi1_data_o", pi1_rdata, 32'h00C3_003C);
		run_op(pi1_pkg::NOOP, 8'h40, 32'hFFFF_FFFF, 4'hF);
		run_op(pi1_pkg::RDOP, 8'h40, '0, 4'hF);
		check_word("pi1_data_o", pi1_rdata, 32'h11C3_333C);

		// Random traffic in a 16 word window.
		for (int k = 0; k < N_OPS; k++) begin
			rand_bits(2, r_op);
			rand_bits(4, r_addr);
			rand_bits(32, r_data);
			rand_bits(4, r_sel);
			run_op(pi1_pkg::pi1_op_e'(r_op[1:0]), {4'h0, r_addr[3:0]}, r_data, r_sel[3:0]);
		end

		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			n_checks, n_errors, dut.u_checker.fail_cnt);
		if (n_errors == 0 && dut.u_checker.fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: wb4_fifo.sv
// Synchronous circular FIFO with a type parameter for its payload.
// Serves as both the request and the response buffer of the memory slave.
`timescale 1ns/1ns
`default_nettype none

module wb4_fifo #(
	parameter type         payload_t = logic,
	parameter int unsigned DEPTH     = 2
) (
	input  logic      clk_i,
	input  logic      arst_n_i,
	input  logic      push_i,
	input  payload_t  data_i,
	input  logic      pop_i,
	output payload_t  data_o,
	output logic      full_o,
	output logic      empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem_q [DEPTH];
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   rd_ptr_q;
	logic [CNT_W-1:0]   count_q;
	logic               do_push;
	logic               do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);

	// Pushes into a full buffer and pops from an empty one are dropped.
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign data_o = mem_q[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: wb4_sram.sv
// Word-wide Wishbone B4 memory slave with request and response buffers.
// Stalls while the request buffer is full and acks from the response buffer.
`timescale 1ns/1ns
`default_nettype none

`include "pi1_defines.svh"

module wb4_sram (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic                wb4_cyc_i,
	input  logic                wb4_stb_i,
	input  pi1_pkg::wb4_req_t   wb4_req_i,
	output logic                wb4_stall_o,
	output logic                wb4_ack_o,
	output pi1_pkg::wb4_rsp_t   wb4_rsp_o
);

	localparam int WORDS = 2 ** `PI1_ADDRBITSZ;

	logic [`PI1_ARCHBITSZ-1:0]  mem [WORDS];
	pi1_pkg::wb4_req_t          req_head;
	logic                       req_push;
	logic                       req_pop;
	logic                       req_full;
	logic                       req_empty;
	logic                       rsp_full;
	logic                       rsp_empty;
	logic [`PI1_ADDRBITSZ-1:0]  word_idx;
	logic                       rd_vld_q;
	pi1_pkg::wb4_rsp_t          rd_rsp_q;

	// Storage starts out cleared.
	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = '0;
		end
	end

	assign req_push    = wb4_cyc_i && wb4_stb_i && !req_full;
	assign wb4_stall_o = req_full;

	wb4_fifo #(
		.payload_t (pi1_pkg::wb4_req_t),
		.DEPTH     (`PI1_FIFO_DEPTH)
	) u_req_fifo (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.push_i   (req_push),
		.data_i   (wb4_req_i),
		.pop_i    (req_pop),
		.data_o   (req_head),
		.full_o   (req_full),
		.empty_o  (req_empty)
	);

	// One request per cycle while there is room for its response.
	assign req_pop  = !req_empty && !rsp_full;
	assign word_idx = req_head.adr[`PI1_ADDRBITSZ+1:2];

	always_ff @(posedge clk_i) begin
		if (req_pop) begin
			rd_rsp_q.dat <= mem[word_idx];
			if (req_head.we) begin
				for (int b = 0; b < `PI1_SELBITSZ; b++) begin
					if (req_head.sel[b]) begin
						mem[word_idx][b*8 +: 8] <= req_head.dat[b*8 +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_vld_q <= 1'b0;
		end else begin
			rd_vld_q <= req_pop;
		end
	end

	wb4_fifo #(
		.payload_t (pi1_pkg::wb4_rsp_t),
		.DEPTH     (`PI1_FIFO_DEPTH)
	) u_rsp_fifo (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.push_i   (rd_vld_q),
		.data_i   (rd_rsp_q),
		.pop_i    (wb4_ack_o),
		.data_o   (wb4_rsp_o),
		.full_o   (rsp_full),
		.empty_o  (rsp_empty)
	);

	assign wb4_ack_o = !rsp_empty;

endmodule

`default_nettype wire
